//--- bp_front.f
+incdir+verification
hdl/bp_pkg.sv
hdl/return_stack.sv
hdl/pattern_table.sv
hdl/line_predecode.sv
hdl/branch_pred.sv
hdl/bp_top.sv
verification/bp_tb.sv

//--- hdl/bp_pkg.sv
package bp_pkg;

  // line geometry
  localparam int LINE_BYTES = 64;
  localparam int LINE_BITS  = 512;   // LINE_BYTES * 8

  localparam int SS_WIDTH = 4;       // max instructions per fetch group

  // gshare sizing
  localparam int GHR_K     = 8;      // global history bits
  localparam int PHT_N     = 8;      // pc bits in the index
  localparam int PHT_IDX_W = GHR_K + PHT_N;

  // return stack sizing
  localparam int RAS_DEPTH = 8;
  localparam int RAS_PTR_W = 3;

  localparam int PC_W   = 64;
  localparam int OFFS_W = 19;        // redirect offset from execute

  // opcode match patterns, compared against the top bits of a word
  localparam logic [5:0]  OP_B     = 6'b000101;     // bits 31..26
  localparam logic [5:0]  OP_BL    = 6'b100101;     // bits 31..26
  localparam logic [10:0] OP_RET   = 11'b11010110010; // bits 31..21
  localparam logic [7:0]  OP_BCOND = 8'b01010100;   // bits 31..24

  // slot classification reported to fetch
  typedef enum logic [2:0] {
    BR_NONE  = 3'd0,  // plain instruction
    BR_B     = 3'd1,
    BR_BL    = 3'd2,  // call, pushes the return address
    BR_RET   = 3'd3,  // return, target from the stack
    BR_BCOND = 3'd4,  // conditional, direction from the pht
    BR_EMPTY = 3'd5   // slot not part of the group
  } br_kind_e;

  // fetch control fsm
  typedef enum logic [1:0] {
    S_IDLE      = 2'd0,  // waiting for start
    S_WAIT_LINE = 2'd1,  // line request outstanding
    S_DROP_LINE = 2'd2,  // outstanding line is stale, redirect pending
    S_HOLD      = 2'd3   // group offered, waiting on fetch_ready
  } bp_state_e;

endpackage

//--- hdl/bp_top.sv
`timescale 1ns/10ps

module bp_top import bp_pkg::*; (
  input  logic                 clk_in,
  input  logic                 rst_N_in,
  input  logic                 start_signal,
  input  logic [PC_W-1:0]      start_pc,
  input  logic                 l1i_valid,
  input  logic [LINE_BITS-1:0] l1i_line,
  input  logic                 fetch_ready,
  input  logic                 x_bcond_resolved,
  input  logic                 x_taken,
  input  logic                 x_redirect,
  input  logic [PC_W-1:0]      x_pc,
  input  logic [OFFS_W-1:0]    x_correction_offset,
  output logic                 l1i_req,
  output logic [PC_W-1:0]      l1i_addr,
  output logic                 pc_valid,
  output logic [PC_W-1:0]      pred_pc,
  output logic [PC_W-1:0]      group_pc,
  output logic [2:0]           group_count,
  output br_kind_e             br_kind [SS_WIDTH],
  output logic [PC_W-1:0]      br_target [SS_WIDTH],
  output logic [SS_WIDTH-1:0]  br_taken
);

  // predecode to controller
  logic [PC_W-1:0]     slot_pc [SS_WIDTH];
  br_kind_e            pd_kind [SS_WIDTH];
  logic [PC_W-1:0]     pd_target [SS_WIDTH];
  logic [SS_WIDTH-1:0] pd_taken;
  logic [2:0]          pd_count;
  logic [PC_W-1:0]     pd_next_pc;
  logic                pd_push;
  logic                pd_pop;
  logic [PC_W-1:0]     pd_push_addr;
  // pht and stack
  logic [SS_WIDTH-1:0] predict_taken;
  logic                stack_push;
  logic                stack_pop;
  logic [PC_W-1:0]     stack_push_addr;
  logic [PC_W-1:0]     ras_top;

  pattern_table u_pht (
    .clk_in        (clk_in),
    .rst_N_in      (rst_N_in),
    .train         (x_bcond_resolved),
    .train_pc      (x_pc),
    .train_taken   (x_taken),
    .lookup_pc     (slot_pc),
    .predict_taken (predict_taken)
  );

  return_stack u_ras (
    .clk_in    (clk_in),
    .rst_N_in  (rst_N_in),
    .push      (stack_push),
    .pop       (stack_pop),
    .push_addr (stack_push_addr),
    .top_addr  (ras_top)
  );

  // scans the returned line from the pc register
  line_predecode u_predecode (
    .line          (l1i_line),
    .group_pc      (pred_pc),
    .ras_top       (ras_top),
    .predict_taken (predict_taken),
    .slot_pc       (slot_pc),
    .kind          (pd_kind),
    .target        (pd_target),
    .taken         (pd_taken),
    .count         (pd_count),
    .next_pc       (pd_next_pc),
    .ras_push      (pd_push),
    .ras_pop       (pd_pop),
    .ras_push_addr (pd_push_addr)
  );

  branch_pred u_ctrl (
    .clk_in              (clk_in),
    .rst_N_in            (rst_N_in),
    .start_signal        (start_signal),
    .start_pc            (start_pc),
    .l1i_valid           (l1i_valid),
    .fetch_ready         (fetch_ready),
    .x_redirect          (x_redirect),
    .x_pc                (x_pc),
    .x_correction_offset (x_correction_offset),
    .kind                (pd_kind),
    .target              (pd_target),
    .taken               (pd_taken),
    .count               (pd_count),
    .next_pc             (pd_next_pc),
    .ras_push            (pd_push),
    .ras_pop             (pd_pop),
    .ras_push_addr       (pd_push_addr),
    .l1i_req             (l1i_req),
    .l1i_addr            (l1i_addr),
    .pc_valid            (pc_valid),
    .pred_pc             (pred_pc),
    .group_pc            (group_pc),
    .group_count         (group_count),
    .br_kind             (br_kind),
    .br_target           (br_target),
    .br_taken            (br_taken),
    .stack_push          (stack_push),
    .stack_pop           (stack_pop),
    .stack_push_addr     (stack_push_addr)
  );

endmodule

//--- hdl/branch_pred.sv
`timescale 1ns/10ps

module branch_pred import bp_pkg::*; (
  input  logic                 clk_in,
  input  logic                 rst_N_in,
  input  logic                 start_signal,
  input  logic [PC_W-1:0]      start_pc,
  input  logic                 l1i_valid,
  input  logic                 fetch_ready,
  input  logic                 x_redirect,
  input  logic [PC_W-1:0]      x_pc,
  input  logic [OFFS_W-1:0]    x_correction_offset,
  // predecode results for the line on l1i
  input  br_kind_e             kind [SS_WIDTH],
  input  logic [PC_W-1:0]      target [SS_WIDTH],
  input  logic [SS_WIDTH-1:0]  taken,
  input  logic [2:0]           count,
  input  logic [PC_W-1:0]      next_pc,
  input  logic                 ras_push,
  input  logic                 ras_pop,
  input  logic [PC_W-1:0]      ras_push_addr,
  // line request
  output logic                 l1i_req,
  output logic [PC_W-1:0]      l1i_addr,
  // group to fetch
  output logic                 pc_valid,
  output logic [PC_W-1:0]      pred_pc,
  output logic [PC_W-1:0]      group_pc,
  output logic [2:0]           group_count,
  output br_kind_e             br_kind [SS_WIDTH],
  output logic [PC_W-1:0]      br_target [SS_WIDTH],
  output logic [SS_WIDTH-1:0]  br_taken,
  // return stack ops
  output logic                 stack_push,
  output logic                 stack_pop,
  output logic [PC_W-1:0]      stack_push_addr
);

  bp_state_e       state;
  logic [PC_W-1:0] redir_pc;      // target parked while a stale line drains
  logic [PC_W-1:0] redir_target;
  logic            req_open;      // request out and its line not here yet
  logic            line_take;     // line arrives for a live request

  assign redir_target = x_pc + {{(PC_W-OFFS_W){x_correction_offset[OFFS_W-1]}},
                                x_correction_offset};

  assign req_open  = ((state == S_WAIT_LINE) || (state == S_DROP_LINE)) && !l1i_valid;
  assign line_take = (state == S_WAIT_LINE) && l1i_valid && !x_redirect;

  assign pc_valid = (state == S_HOLD);  // group registers are live only here

  // stack moves only with a line that is kept
  assign stack_push      = line_take && ras_push;
  assign stack_pop       = line_take && ras_pop;
  assign stack_push_addr = ras_push_addr;

  // pred_pc doubles as the pc register, predecode scans from it
  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      state       <= S_IDLE;
      l1i_req     <= 1'b0;
      l1i_addr    <= '0;
      pred_pc     <= '0;
      redir_pc    <= '0;
      group_pc    <= '0;
      group_count <= '0;
      br_kind     <= '{default: BR_NONE};
      br_target   <= '{default: '0};
      br_taken    <= '0;
    end else begin
      l1i_req <= 1'b0;  // one cycle pulse
      if (x_redirect) begin
        // redirect wins over start, line and acceptance
        if (req_open) begin
          state    <= S_DROP_LINE;  // let the stale line land first
          redir_pc <= redir_target;
        end else begin
          state    <= S_WAIT_LINE;
          l1i_req  <= 1'b1;
          l1i_addr <= redir_target & ~PC_W'(LINE_BYTES - 1);
          pred_pc  <= redir_target;
        end
      end else begin
        case (state)
          S_IDLE: begin
            if (start_signal) begin
              state    <= S_WAIT_LINE;
              l1i_req  <= 1'b1;
              l1i_addr <= start_pc & ~PC_W'(LINE_BYTES - 1);
              pred_pc  <= start_pc;
            end
          end
          S_WAIT_LINE: begin
            if (l1i_valid) begin
              state       <= S_HOLD;
              group_pc    <= pred_pc;  // group starts at the old pc
              pred_pc     <= next_pc;
              group_count <= count;
              br_kind     <= kind;
              br_target   <= target;
              br_taken    <= taken;
            end
          end
          S_DROP_LINE: begin
            if (l1i_valid) begin
              // stale line discarded, request the redirect line next
              state    <= S_WAIT_LINE;
              l1i_req  <= 1'b1;
              l1i_addr <= redir_pc & ~PC_W'(LINE_BYTES - 1);
              pred_pc  <= redir_pc;
            end
          end
          S_HOLD: begin
            if (fetch_ready) begin
              state    <= S_WAIT_LINE;  // group taken, go for the next line
              l1i_req  <= 1'b1;
              l1i_addr <= pred_pc & ~PC_W'(LINE_BYTES - 1);
            end
          end
          default: state <= S_IDLE;
        endcase
      end
    end
  end

endmodule

//--- hdl/line_predecode.sv
`timescale 1ns/10ps

module line_predecode import bp_pkg::*; (
  input  logic [LINE_BITS-1:0] line,
  input  logic [PC_W-1:0]      group_pc,        // first instruction of the group
  input  logic [PC_W-1:0]      ras_top,
  input  logic [SS_WIDTH-1:0]  predict_taken,   // from the pht, per slot
  output logic [PC_W-1:0]      slot_pc [SS_WIDTH],
  output br_kind_e             kind [SS_WIDTH],
  output logic [PC_W-1:0]      target [SS_WIDTH],
  output logic [SS_WIDTH-1:0]  taken,
  output logic [2:0]           count,
  output logic [PC_W-1:0]      next_pc,
  output logic                 ras_push,
  output logic                 ras_pop,
  output logic [PC_W-1:0]      ras_push_addr
);

  logic [PC_W-1:0]     base_pc;              // group_pc, word aligned
  logic [31:0]         ins [SS_WIDTH];
  logic [SS_WIDTH-1:0] in_line;              // slot still inside this line
  br_kind_e            raw_kind [SS_WIDTH];  // classification before group cut
  logic [PC_W-1:0]     raw_target [SS_WIDTH];
  logic [SS_WIDTH-1:0] raw_taken;
  logic                group_end;            // a taken slot closed the group

  function automatic br_kind_e classify(input logic [31:0] word);
    if (word[31:21] == OP_RET) begin
      return BR_RET;
    end else if (word[31:26] == OP_B) begin
      return BR_B;
    end else if (word[31:26] == OP_BL) begin
      return BR_BL;
    end else if (word[31:24] == OP_BCOND) begin
      return BR_BCOND;
    end
    return BR_NONE;
  endfunction

  // byte offset of the branch, immediates are in words
  function automatic logic [PC_W-1:0] branch_offset(input logic [31:0] word,
                                                    input br_kind_e k);
    case (k)
      BR_B, BR_BL: return {{(PC_W-28){word[25]}}, word[25:0], 2'b00};  // imm26
      BR_BCOND:    return {{(PC_W-21){word[23]}}, word[23:5], 2'b00};  // imm19
      default:     return '0;
    endcase
  endfunction

  assign base_pc = {group_pc[PC_W-1:2], 2'b00};

  for (genvar i = 0; i < SS_WIDTH; i++) begin : g_slot
    logic [4:0] slot_idx;  // word index in the line, bit 4 means past the end

    assign slot_idx   = {1'b0, group_pc[5:2]} + 5'(i);
    assign in_line[i] = (slot_idx < 5'(LINE_BYTES/4));
    assign ins[i]     = line[{slot_idx[3:0], 5'd0} +: 32];  // little endian word
    assign slot_pc[i] = base_pc + PC_W'(4*i);

    assign raw_kind[i] = classify(ins[i]);
    assign raw_target[i] = (raw_kind[i] == BR_RET)  ? ras_top :
                           (raw_kind[i] == BR_NONE) ? '0 :
                           slot_pc[i] + branch_offset(ins[i], raw_kind[i]);
    // unconditional kinds always redirect, B.cond follows its counter
    assign raw_taken[i] = (raw_kind[i] == BR_B) || (raw_kind[i] == BR_BL) ||
                          (raw_kind[i] == BR_RET) ||
                          ((raw_kind[i] == BR_BCOND) && predict_taken[i]);
  end

  // walk the slots in order, the first taken branch closes the group
  always_comb begin
    group_end     = 1'b0;
    count         = '0;
    next_pc       = '0;
    ras_push      = 1'b0;
    ras_pop       = 1'b0;
    ras_push_addr = '0;
    for (int i = 0; i < SS_WIDTH; i++) begin
      kind[i]   = BR_EMPTY;  // default for slots outside the group
      target[i] = '0;
      taken[i]  = 1'b0;
      if (in_line[i] && !group_end) begin
        kind[i]   = raw_kind[i];
        target[i] = raw_target[i];
        taken[i]  = raw_taken[i];
        count     = count + 3'd1;
        if (raw_taken[i]) begin
          group_end     = 1'b1;
          next_pc       = raw_target[i];
          ras_push      = (raw_kind[i] == BR_BL);
          ras_pop       = (raw_kind[i] == BR_RET);
          ras_push_addr = (raw_kind[i] == BR_BL) ? slot_pc[i] + PC_W'(4) : '0;
        end
      end
    end
    // fall through to the word after the group
    if (!group_end) begin
      next_pc = base_pc + PC_W'({count, 2'b00});
    end
  end

endmodule

//--- hdl/pattern_table.sv
`timescale 1ns/10ps

module pattern_table import bp_pkg::*; (
  input  logic                clk_in,
  input  logic                rst_N_in,
  input  logic                train,        // resolved B.cond from execute
  input  logic [PC_W-1:0]     train_pc,
  input  logic                train_taken,
  input  logic [PC_W-1:0]     lookup_pc [SS_WIDTH],  // one per slot
  output logic [SS_WIDTH-1:0] predict_taken
);

  logic [GHR_K-1:0]     ghr;                  // newest outcome in bit 0
  logic [1:0]           pht [2**PHT_IDX_W];   // 2-bit saturating counters
  logic [PHT_IDX_W-1:0] train_idx;
  logic [1:0]           train_ctr;

  // gshare index is history over pc bits, word aligned
  assign train_idx = {ghr, train_pc[PHT_N+1:2]};
  assign train_ctr = pht[train_idx];

  for (genvar i = 0; i < SS_WIDTH; i++) begin : g_lookup
    logic [PHT_IDX_W-1:0] idx;
    assign idx              = {ghr, lookup_pc[i][PHT_N+1:2]};
    assign predict_taken[i] = pht[idx][1];  // weakly or strongly taken
  end

  // lookup in the training cycle sees the old counters and history
  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      ghr <= '0;
      pht <= '{default: 2'b00};
    end else if (train) begin
      if (train_taken) begin
        if (train_ctr != 2'b11) begin
          pht[train_idx] <= train_ctr + 2'b01;
        end
      end else begin
        if (train_ctr != 2'b00) begin
          pht[train_idx] <= train_ctr - 2'b01;
        end
      end
      ghr <= {ghr[GHR_K-2:0], train_taken};  // shift in the outcome
    end
  end

endmodule

//--- hdl/return_stack.sv
`timescale 1ns/10ps

module return_stack import bp_pkg::*; (
  input  logic            clk_in,
  input  logic            rst_N_in,
  input  logic            push,       // from an accepted BL
  input  logic            pop,        // from an accepted RET
  input  logic [PC_W-1:0] push_addr,
  output logic [PC_W-1:0] top_addr
);

  logic [PC_W-1:0]      entry [RAS_DEPTH];  // circular storage
  logic [RAS_PTR_W-1:0] top_ptr;            // slot of the newest entry
  logic [RAS_PTR_W-1:0] push_ptr;
  logic [RAS_PTR_W:0]   occupancy;          // 0 .. RAS_DEPTH

  assign push_ptr = top_ptr + RAS_PTR_W'(1);  // wraps onto the oldest entry when full

  // empty stack predicts address zero
  assign top_addr = (occupancy == '0) ? '0 : entry[top_ptr];

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      top_ptr   <= '0;
      occupancy <= '0;
    end else if (push) begin
      top_ptr <= push_ptr;
      if (occupancy != (RAS_PTR_W+1)'(RAS_DEPTH)) begin
        occupancy <= occupancy + 1'b1;  // saturate, overflow loses the oldest
      end
    end else if (pop && occupancy != '0) begin
      top_ptr   <= top_ptr - RAS_PTR_W'(1);
      occupancy <= occupancy - 1'b1;
    end
    // pop on empty falls through and changes nothing
  end

  // entry data
  always_ff @(posedge clk_in) begin
    if (push) begin
      entry[push_ptr] <= push_addr;
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator and run it
# exit status is the simulator's, nonzero after $fatal
cd "$(dirname "$0")" || exit 1
verilator --binary -sv -Wno-fatal --top-module bp_tb -f bp_front.f -o bp_sim \
  && ./obj_dir/bp_sim \
  || exit 1

//--- verification/bp_tests.svh
localparam logic [31:0] RET_X30 = 32'hd65f_03c0;  // ret through x30

// pc relative encoders, immediates count words
function automatic logic [31:0] enc_b(input logic [PC_W-1:0] pc, tgt, input logic link);
  logic [PC_W-1:0] off;
  off = (tgt - pc) >> 2;
  return {link ? 6'b100101 : 6'b000101, off[25:0]};
endfunction

function automatic logic [31:0] enc_bcond(input logic [PC_W-1:0] pc, tgt);
  logic [PC_W-1:0] off;
  off = (tgt - pc) >> 2;
  return {8'b01010100, off[18:0], 5'b00000};  // b.eq
endfunction

task automatic test_sequential();
  reset_dut();
  start_at(64'h1038);  // two words left in the line
  wait_group();
  check_group(64'h1038, 64'h1040, 2);
  check_slots(0, 1, BR_NONE);
  check_slots(2, 3, BR_EMPTY);
  accept_group(64'h1040);
  wait_group();
  check_group(64'h1040, 64'h1050, 4);
  check_slots(0, 3, BR_NONE);
endtask

task automatic test_call_return();
  reset_dut();
  code[64'h2004] = enc_b(64'h2004, 64'h2400, 1'b0);
  code[64'h2400] = enc_b(64'h2400, 64'h1800, 1'b1);  // backward call
  code[64'h1808] = RET_X30;
  start_at(64'h2000);
  wait_group();
  check_group(64'h2000, 64'h2400, 2);
  check_slots(0, 0, BR_NONE);
  check_slot(1, BR_B, 64'h2400, 1'b1);
  check_slots(2, 3, BR_EMPTY);
  accept_group(64'h2400);
  wait_group();
  model_push(64'h2404);  // return address of the call
  check_group(64'h2400, 64'h1800, 1);
  check_slot(0, BR_BL, 64'h1800, 1'b1);
  check_slots(1, 3, BR_EMPTY);
  accept_group(64'h1800);
  wait_group();
  check_group(64'h1800, model_top(), 3);
  check_slots(0, 1, BR_NONE);
  check_slot(2, BR_RET, model_top(), 1'b1);
  void'(model_ras.pop_back());
endtask

// same line before and after training, direction from the model pht
task automatic check_bcond_line();
  logic tk;
  tk = model_taken(64'h3004);
  check_group(64'h3000, tk ? 64'h3104 : 64'h3010, tk ? 3'd2 : 3'd4);
  check_slots(0, 0, BR_NONE);
  check_slot(1, BR_BCOND, 64'h3104, tk);
  check_slots(2, 3, tk ? BR_EMPTY : BR_NONE);
endtask

task automatic test_bcond_training();
  reset_dut();
  code[64'h3004] = enc_bcond(64'h3004, 64'h3104);
  start_at(64'h3000);
  wait_group();
  check_bcond_line();
  // fill history with taken, then two more land on one counter
  repeat (GHR_K + 2) train_bcond(64'h3004, 1'b1);
  redirect(64'h3000, '0);
  expect_req(64'h3000);
  wait_group();
  check_bcond_line();
endtask

task automatic test_redirect_drop();
  reset_dut();
  code[64'h4000] = enc_b(64'h4000, 64'h4800, 1'b1);  // call in the stale line
  code[64'h40e8] = RET_X30;
  start_at(64'h4000);
  redirect(64'h4100, OFFS_W'(-32));  // back to 0x40e0 while the line is out
  while (l1i_req !== 1'b1) begin
    check_bit("pc_valid while draining", pc_valid, 0);
    @(negedge clk_in);
  end
  expect_req(64'h40e0);
  wait_group();
  check_group(64'h40e0, model_top(), 3);
  check_slots(0, 1, BR_NONE);
  check_slot(2, BR_RET, model_top(), 1'b1);
  check_slots(3, 3, BR_EMPTY);
endtask

task automatic test_back_pressure();
  reset_dut();
  code[64'h5010] = enc_b(64'h5010, 64'h5800, 1'b0);
  start_at(64'h5008);
  wait_group();
  repeat (6) begin
    check_group(64'h5008, 64'h5800, 3);
    check_slots(0, 1, BR_NONE);
    check_slot(2, BR_B, 64'h5800, 1'b1);
    check_slots(3, 3, BR_EMPTY);
    check_bit("l1i_req while held", l1i_req, 0);
    @(negedge clk_in);
  end
  accept_group(64'h5800);
  wait_group();
  check_group(64'h5800, 64'h5810, 4);
endtask

//--- verification/bp_tb.sv
`timescale 1ns/10ps

module bp_tb import bp_pkg::*; ();

  localparam int MAX_CYCLES = 2000;  // far above the cycles the suite runs

  logic                 clk_in;
  logic                 rst_N_in;
  logic                 start_signal;
  logic                 l1i_valid;
  logic                 fetch_ready;
  logic                 x_bcond_resolved;
  logic                 x_taken;
  logic                 x_redirect;
  logic                 l1i_req;
  logic                 pc_valid;
  logic [PC_W-1:0]      start_pc;
  logic [PC_W-1:0]      x_pc;
  logic [PC_W-1:0]      l1i_addr;
  logic [PC_W-1:0]      pred_pc;
  logic [PC_W-1:0]      group_pc;
  logic [LINE_BITS-1:0] l1i_line;
  logic [OFFS_W-1:0]    x_correction_offset;
  logic [2:0]           group_count;
  br_kind_e             br_kind [SS_WIDTH];
  logic [PC_W-1:0]      br_target [SS_WIDTH];
  logic [SS_WIDTH-1:0]  br_taken;
  integer               seed = 32'hb96f_ea8b;  // line latency draws
  int                   cycle_cnt = 0;
  // reference state
  logic [31:0]          code [logic [PC_W-1:0]];           // placed words by address
  logic [1:0]           model_pht [logic [PHT_IDX_W-1:0]];  // missing entry reads as 0
  logic [GHR_K-1:0]     model_ghr;
  logic [PC_W-1:0]      model_ras [$];                     // newest at the back

  bp_top uut (.*);

  initial begin
    clk_in = 1'b0;
    forever #50 clk_in = ~clk_in;
  end

  initial begin
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_in);
      cycle_cnt++;
    end
    $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
    report_fail();
  end

  // filler words are add immediates that vary with the whole address
  function automatic logic [LINE_BITS-1:0] build_line(input logic [PC_W-1:0] base);
    logic [LINE_BITS-1:0] l;
    logic [PC_W-1:0]      a;
    for (int i = 0; i < LINE_BYTES/4; i++) begin
      a = base + PC_W'(4*i);
      l[32*i +: 32] = code.exists(a) ? code[a] : {8'h91, 24'(a ^ (a >> 24) ^ (a >> 48))};
    end
    return l;
  endfunction

  // l1i model answers each request with one line after 1 to 3 cycles
  initial begin : line_model
    int              dly;
    logic [PC_W-1:0] addr;
    dly       = 0;
    l1i_valid = 1'b0;
    l1i_line  = '0;
    forever begin
      @(negedge clk_in);
      l1i_valid = 1'b0;  // pulse
      if (dly > 0) begin
        dly--;
        if (dly == 0) begin
          l1i_line  = build_line(addr);
          l1i_valid = 1'b1;
        end
      end
      if (l1i_req) begin
        addr = l1i_addr;
        dly  = 1 + int'($unsigned($random(seed)) % 3);
      end
    end
  end

  task automatic report_fail();
    $display("=== FAIL ===");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_pc(input string what, input logic [PC_W-1:0] got, exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      report_fail();
    end
  endtask

  task automatic check_kind(input string what, input br_kind_e got, exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
      report_fail();
    end
  endtask

  task automatic check_bit(input string what, input logic [2:0] got, exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      report_fail();
    end
  endtask

  task automatic check_group(input logic [PC_W-1:0] gpc, ppc, input logic [2:0] cnt);
    check_bit("pc_valid", pc_valid, 1);
    check_pc("group_pc", group_pc, gpc);
    check_pc("pred_pc", pred_pc, ppc);
    check_bit("group_count", group_count, cnt);
  endtask

  task automatic check_slot(input int i, input br_kind_e k, input logic [PC_W-1:0] tgt,
                            input logic tk);
    check_kind($sformatf("br_kind[%0d]", i), br_kind[i], k);
    check_pc($sformatf("br_target[%0d]", i), br_target[i], tgt);
    check_bit($sformatf("br_taken[%0d]", i), br_taken[i], tk);
  endtask

  // plain and empty slots carry no target and no taken flag
  task automatic check_slots(input int first, last, input br_kind_e k);
    for (int i = first; i <= last; i++) begin
      check_slot(i, k, '0, 1'b0);
    end
  endtask

  function automatic logic model_taken(input logic [PC_W-1:0] pc);
    logic [PHT_IDX_W-1:0] idx;
    idx = {model_ghr, pc[PHT_N+1:2]};
    return model_pht.exists(idx) && (model_pht[idx] >= 2'd2);
  endfunction

  function automatic logic [PC_W-1:0] model_top();
    return (model_ras.size() > 0) ? model_ras[$] : '0;  // empty stack gives zero
  endfunction

  task automatic model_push(input logic [PC_W-1:0] addr);
    model_ras.push_back(addr);
    if (model_ras.size() > RAS_DEPTH) begin
      void'(model_ras.pop_front());  // oldest entry lost
    end
  endtask

  task automatic reset_dut();
    code.delete();
    model_pht.delete();
    model_ras.delete();
    model_ghr = '0;
    @(negedge clk_in);
    rst_N_in = 1'b1;
    repeat (3) @(negedge clk_in);
    rst_N_in = 1'b0;
  endtask

  task automatic expect_req(input logic [PC_W-1:0] pc);
    check_bit("l1i_req", l1i_req, 1);
    check_pc("l1i_addr", l1i_addr, pc - PC_W'(pc % LINE_BYTES));
  endtask

  task automatic start_at(input logic [PC_W-1:0] pc);
    start_signal = 1'b1;
    start_pc     = pc;
    @(negedge clk_in);
    start_signal = 1'b0;
    expect_req(pc);  // request in the cycle after start
  endtask

  task automatic wait_group();
    while (pc_valid !== 1'b1) @(negedge clk_in);
  endtask

  task automatic accept_group(input logic [PC_W-1:0] next_pc);
    fetch_ready = 1'b1;
    @(negedge clk_in);
    fetch_ready = 1'b0;
    check_bit("pc_valid after accept", pc_valid, 0);
    expect_req(next_pc);
  endtask

  task automatic redirect(input logic [PC_W-1:0] pc, input logic [OFFS_W-1:0] off);
    x_redirect          = 1'b1;
    x_pc                = pc;
    x_correction_offset = off;
    @(negedge clk_in);
    x_redirect = 1'b0;
  endtask

  // model and dut train on the same resolved B.cond
  task automatic train_bcond(input logic [PC_W-1:0] pc, input logic tk);
    logic [PHT_IDX_W-1:0] idx;
    logic [1:0]           c;
    idx = {model_ghr, pc[PHT_N+1:2]};
    c   = model_pht.exists(idx) ? model_pht[idx] : 2'd0;
    if (tk && c != 2'd3) begin
      c++;
    end else if (!tk && c != 2'd0) begin
      c--;
    end
    model_pht[idx] = c;
    model_ghr      = {model_ghr[GHR_K-2:0], tk};
    x_bcond_resolved = 1'b1;
    x_pc             = pc;
    x_taken          = tk;
    @(negedge clk_in);
    x_bcond_resolved = 1'b0;
  endtask

  `include "bp_tests.svh"

  initial begin
    rst_N_in            = 1'b1;
    start_signal        = 1'b0;
    start_pc            = '0;
    fetch_ready         = 1'b0;
    x_bcond_resolved    = 1'b0;
    x_taken             = 1'b0;
    x_redirect          = 1'b0;
    x_pc                = '0;
    x_correction_offset = '0;
    test_sequential();
    test_call_return();
    test_bcond_training();
    test_redirect_drop();
    test_back_pressure();
    $display("=== PASS ===");
    $finish;
  end

endmodule
